// File: cim_params.svh
`ifndef CIM_PARAMS_SVH
`define CIM_PARAMS_SVH

// Crossbar geometry
`define XBAR_SIZE   16
`define OUT_COLS    4
`define INPUT_SIZE  12

// Datapath widths
`define DATA_W      8
`define ACC_W       20  // 16 products of 255 x 255 fit
`define ADDR_W      4

`endif

// File: cim_pkg.sv
`default_nettype none

package cim_pkg;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,     // Waiting for the clear to be granted
        ST_LOAD,
        ST_HANDOFF
    } ctrl_state_e;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_CLEAR,
        OP_INPUT,
        OP_WEIGHT
    } xbar_op_e;

endpackage

`default_nettype wire

// File: cim_apb_regs.sv
`default_nettype none
`include "cim_params.svh"

module cim_apb_regs import cim_pkg::*; (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               i_psel,
    input  wire                               i_penable,
    input  wire                               i_pwrite,
    input  wire        [11:0]                 i_paddr,
    input  wire        [31:0]                 i_pwdata,
    input  wire                               i_ctrl_busy,
    input  wire                               i_done_pulse,
    input  wire        [$clog2(`INPUT_SIZE)-1:0] i_in_idx,
    input  wire        [`ACC_W-1:0]           i_acc_data,
    output logic       [31:0]                 o_prdata,
    output logic                              o_pready,
    output logic                              o_start,
    output logic       [`DATA_W-1:0]          o_in_data,
    output logic       [$clog2(`OUT_COLS)-1:0] o_acc_col,
    output logic                              o_wreq,
    output xbar_op_e                          o_wop,
    output logic       [`ADDR_W-1:0]          o_wrow,
    output logic       [$clog2(`OUT_COLS)-1:0] o_wcol,
    output logic       [`DATA_W-1:0]          o_wdata
);

    localparam int IDX_W = $clog2(`INPUT_SIZE);
    localparam int COL_W = $clog2(`OUT_COLS);

    localparam logic [11:0] CTRL_ADDR   = 12'h000;
    localparam logic [11:0] STATUS_ADDR = 12'h004;
    localparam logic [11:0] IN_BASE     = 12'h040;
    localparam logic [11:0] W_BASE      = 12'h400;
    localparam logic [11:0] ACC_BASE    = 12'h800;

    logic [`DATA_W-1:0] in_buf [`INPUT_SIZE];
    logic               done;
    logic               wr_en;
    logic               rd_en;
    logic [11:0]        in_off;
    logic [11:0]        w_off;
    logic [11:0]        acc_off;
    logic               in_hit;
    logic               w_hit;
    logic               acc_hit;

    assign wr_en = i_psel && i_penable && i_pwrite;  // Access phase only
    assign rd_en = i_psel && i_penable && !i_pwrite;

    // Word offsets into each window
    assign in_off  = (i_paddr - IN_BASE) >> 2;
    assign w_off   = (i_paddr - W_BASE) >> 2;
    assign acc_off = (i_paddr - ACC_BASE) >> 2;

    assign in_hit  = (i_paddr >= IN_BASE) && (in_off < `INPUT_SIZE);
    assign w_hit   = (i_paddr >= W_BASE) && (w_off < `XBAR_SIZE * `OUT_COLS);
    assign acc_hit = (i_paddr >= ACC_BASE) && (acc_off < `OUT_COLS);

    assign o_pready = 1'b1;
    assign o_start  = wr_en && (i_paddr == CTRL_ADDR) && i_pwdata[0];

    // Weight writes go straight to the crossbar port
    assign o_wreq  = wr_en && w_hit;
    assign o_wop   = o_wreq ? OP_WEIGHT : OP_NONE;
    assign o_wcol  = w_off[COL_W-1:0];
    assign o_wrow  = w_off[COL_W +: `ADDR_W];  // Row above the column bits
    assign o_wdata = i_pwdata[`DATA_W-1:0];

    assign o_acc_col = acc_off[COL_W-1:0];
    assign o_in_data = in_buf[i_in_idx];

    always_ff @(posedge clk) begin
        if (wr_en && in_hit) begin
            in_buf[in_off[IDX_W-1:0]] <= i_pwdata[`DATA_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (i_done_pulse) begin
            done <= 1'b1;
        end else if (o_start && !i_ctrl_busy) begin
            done <= 1'b0;  // Only an accepted start clears it
        end
    end

    always_comb begin
        o_prdata = '0;
        if (rd_en) begin
            if (i_paddr == STATUS_ADDR) begin
                o_prdata = {30'b0, done, i_ctrl_busy};
            end else if (in_hit) begin
                o_prdata = 32'(in_buf[in_off[IDX_W-1:0]]);
            end else if (acc_hit) begin
                o_prdata = 32'(i_acc_data);
            end
        end
    end

endmodule

`default_nettype wire

// File: cim_port_arbiter.sv
`default_nettype none
`include "cim_params.svh"

module cim_port_arbiter import cim_pkg::*; (
    input  wire                                i_apb_req,
    input  wire xbar_op_e                      i_apb_op,
    input  wire        [`ADDR_W-1:0]           i_apb_row,
    input  wire        [$clog2(`OUT_COLS)-1:0] i_apb_col,
    input  wire        [`DATA_W-1:0]           i_apb_data,
    input  wire                                i_ctl_req,
    input  wire xbar_op_e                      i_ctl_op,
    input  wire        [`ADDR_W-1:0]           i_ctl_row,
    input  wire        [`DATA_W-1:0]           i_ctl_data,
    output logic                               o_ctl_gnt,
    output xbar_op_e                           o_op,
    output logic       [`ADDR_W-1:0]           o_row,
    output logic       [$clog2(`OUT_COLS)-1:0] o_col,
    output logic       [`DATA_W-1:0]           o_data
);

    assign o_ctl_gnt = i_ctl_req && !i_apb_req;  // APB always wins

    always_comb begin
        o_op   = OP_NONE;
        o_row  = '0;
        o_col  = '0;
        o_data = '0;
        if (i_apb_req) begin
            o_op   = i_apb_op;
            o_row  = i_apb_row;
            o_col  = i_apb_col;
            o_data = i_apb_data;
        end else if (i_ctl_req) begin
            o_op   = i_ctl_op;
            o_row  = i_ctl_row;
            o_data = i_ctl_data;  // Column unused for clear and input
        end
    end

endmodule

`default_nettype wire

// File: cim_layer_ctrl.sv
`default_nettype none
`include "cim_params.svh"

module cim_layer_ctrl import cim_pkg::*; (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 i_start,
    input  wire                                 i_gnt,
    input  wire        [`DATA_W-1:0]            i_in_data,
    input  wire                                 i_next_busy,
    output logic                                o_req,
    output xbar_op_e                            o_op,
    output logic       [`ADDR_W-1:0]            o_row,
    output logic       [`DATA_W-1:0]            o_data,
    output logic       [$clog2(`INPUT_SIZE)-1:0] o_in_idx,
    output logic                                o_busy,
    output logic                                o_done_pulse,
    output logic                                o_next_start
);

    localparam int IDX_W = $clog2(`INPUT_SIZE);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`INPUT_SIZE - 1);

    ctrl_state_e      state;
    ctrl_state_e      next_state;
    logic [IDX_W-1:0] in_cnt;
    logic [IDX_W-1:0] next_in_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            in_cnt <= '0;
        end else begin
            state  <= next_state;
            in_cnt <= next_in_cnt;
        end
    end

    always_comb begin
        next_state  = state;
        next_in_cnt = in_cnt;
        case (state)
            ST_IDLE: begin
                if (i_start) begin
                    next_state  = ST_WAIT;
                    next_in_cnt = '0;
                end
            end
            ST_WAIT: begin
                if (i_gnt) begin  // Clear accepted
                    next_state = ST_LOAD;
                end
            end
            ST_LOAD: begin
                if (i_gnt) begin
                    if (in_cnt == LAST_IDX) begin
                        next_state  = ST_HANDOFF;
                        next_in_cnt = '0;
                    end else begin
                        next_in_cnt = in_cnt + 1'b1;
                    end
                end
            end
            ST_HANDOFF: begin
                if (!i_next_busy) begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    // Request held until granted, nothing moves in between
    assign o_req  = (state == ST_WAIT) || (state == ST_LOAD);
    assign o_op   = (state == ST_WAIT) ? OP_CLEAR :
                    (state == ST_LOAD) ? OP_INPUT : OP_NONE;
    assign o_row  = `ADDR_W'(in_cnt);  // One tile, row equals input index
    assign o_data = i_in_data;
    assign o_in_idx = in_cnt;

    assign o_busy       = (state != ST_IDLE);
    assign o_next_start = (state == ST_HANDOFF) && !i_next_busy;
    assign o_done_pulse = o_next_start;

endmodule

`default_nettype wire

// File: cim_xbar.sv
`default_nettype none
`include "cim_params.svh"

module cim_xbar import cim_pkg::*; (
    input  wire                                clk,
    input  wire                                rst,
    input  wire xbar_op_e                      i_op,
    input  wire        [`ADDR_W-1:0]           i_row,
    input  wire        [$clog2(`OUT_COLS)-1:0] i_col,
    input  wire        [`DATA_W-1:0]           i_data,
    input  wire        [$clog2(`OUT_COLS)-1:0] i_rd_col,
    output logic       [`ACC_W-1:0]            o_rd_acc
);

    logic [`DATA_W-1:0]   weights [`XBAR_SIZE][`OUT_COLS];
    logic [`ACC_W-1:0]    acc [`OUT_COLS];
    logic [2*`DATA_W-1:0] prod [`OUT_COLS];

    // Weight memory
    always_ff @(posedge clk) begin
        if (i_op == OP_WEIGHT) begin
            weights[i_row][i_col] <= i_data;
        end
    end

    always_comb begin
        for (int c = 0; c < `OUT_COLS; c++) begin
            prod[c] = i_data * weights[i_row][c];
        end
    end

    // Every column accumulates in parallel
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < `OUT_COLS; c++) begin
                acc[c] <= '0;
            end
        end else begin
            for (int c = 0; c < `OUT_COLS; c++) begin
                case (i_op)
                    OP_CLEAR: acc[c] <= '0;
                    OP_INPUT: acc[c] <= acc[c] + prod[c];
                    default:  acc[c] <= acc[c];
                endcase
            end
        end
    end

    assign o_rd_acc = acc[i_rd_col];

endmodule

`default_nettype wire

// File: cim_layer_top.sv
`default_nettype none
`include "cim_params.svh"

module cim_layer_top import cim_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         i_psel,
    input  wire         i_penable,
    input  wire         i_pwrite,
    input  wire  [11:0] i_paddr,
    input  wire  [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    input  wire         i_next_busy,
    output logic        o_next_start
);

    localparam int IDX_W = $clog2(`INPUT_SIZE);
    localparam int COL_W = $clog2(`OUT_COLS);

    logic               start;
    logic               ctrl_busy;
    logic               done_pulse;
    logic [IDX_W-1:0]   in_idx;
    logic [`DATA_W-1:0] in_data;
    logic [COL_W-1:0]   acc_col;
    logic [`ACC_W-1:0]  acc_data;

    // APB side of the port
    logic               apb_req;
    xbar_op_e           apb_op;
    logic [`ADDR_W-1:0] apb_row;
    logic [COL_W-1:0]   apb_col;
    logic [`DATA_W-1:0] apb_data;

    // Controller side of the port
    logic               ctl_req;
    logic               ctl_gnt;
    xbar_op_e           ctl_op;
    logic [`ADDR_W-1:0] ctl_row;
    logic [`DATA_W-1:0] ctl_data;

    // Granted access
    xbar_op_e           x_op;
    logic [`ADDR_W-1:0] x_row;
    logic [COL_W-1:0]   x_col;
    logic [`DATA_W-1:0] x_data;

    cim_apb_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .i_ctrl_busy  (ctrl_busy),
        .i_done_pulse (done_pulse),
        .i_in_idx     (in_idx),
        .i_acc_data   (acc_data),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_start      (start),
        .o_in_data    (in_data),
        .o_acc_col    (acc_col),
        .o_wreq       (apb_req),
        .o_wop        (apb_op),
        .o_wrow       (apb_row),
        .o_wcol       (apb_col),
        .o_wdata      (apb_data)
    );

    cim_port_arbiter u_arb (
        .i_apb_req  (apb_req),
        .i_apb_op   (apb_op),
        .i_apb_row  (apb_row),
        .i_apb_col  (apb_col),
        .i_apb_data (apb_data),
        .i_ctl_req  (ctl_req),
        .i_ctl_op   (ctl_op),
        .i_ctl_row  (ctl_row),
        .i_ctl_data (ctl_data),
        .o_ctl_gnt  (ctl_gnt),
        .o_op       (x_op),
        .o_row      (x_row),
        .o_col      (x_col),
        .o_data     (x_data)
    );

    cim_layer_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_start      (start),
        .i_gnt        (ctl_gnt),
        .i_in_data    (in_data),
        .i_next_busy  (i_next_busy),
        .o_req        (ctl_req),
        .o_op         (ctl_op),
        .o_row        (ctl_row),
        .o_data       (ctl_data),
        .o_in_idx     (in_idx),
        .o_busy       (ctrl_busy),
        .o_done_pulse (done_pulse),
        .o_next_start (o_next_start)
    );

    cim_xbar u_xbar (
        .clk      (clk),
        .rst      (rst),
        .i_op     (x_op),
        .i_row    (x_row),
        .i_col    (x_col),
        .i_data   (x_data),
        .i_rd_col (acc_col),
        .o_rd_acc (acc_data)
    );

endmodule

`default_nettype wire

// File: cim_assert.sv
`default_nettype none
`include "cim_params.svh"

module cim_assert import cim_pkg::*; (
    input wire                     clk,
    input wire                     rst,
    input wire                     i_apb_req,
    input wire                     i_ctl_req,
    input wire                     i_ctl_gnt,
    input wire xbar_op_e           i_ctl_op,
    input wire [`ADDR_W-1:0]       i_ctl_row,
    input wire ctrl_state_e        i_state,
    input wire                     i_next_busy,
    input wire                     i_next_start
);
    timeunit 1ns;
    timeprecision 1ps;

    a_start_single: assert property (@(posedge clk) disable iff (rst)
        i_next_start |=> !i_next_start)
        else $error("next-layer start held for two cycles");

    // Handoff waits out a busy next layer
    a_start_free: assert property (@(posedge clk) disable iff (rst)
        (i_state == ST_HANDOFF && i_next_busy) |=>
            (i_state == ST_HANDOFF && !$past(i_next_start)))
        else $error("next-layer start while next layer busy");

    // Stalled request keeps its access
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (i_ctl_req && !i_ctl_gnt) |=>
            (i_ctl_req && i_ctl_op == $past(i_ctl_op) && i_ctl_row == $past(i_ctl_row)))
        else $error("controller request changed while stalled");

    // APB write stalls the controller
    a_apb_prio: assert property (@(posedge clk) disable iff (rst)
        (i_apb_req && i_ctl_req) |=>
            (i_ctl_req && i_ctl_op == $past(i_ctl_op) && i_ctl_row == $past(i_ctl_row)))
        else $error("controller granted during APB request");

endmodule

bind cim_layer_top cim_assert i_assert (
    .clk          (clk),
    .rst          (rst),
    .i_apb_req    (apb_req),
    .i_ctl_req    (ctl_req),
    .i_ctl_gnt    (ctl_gnt),
    .i_ctl_op     (ctl_op),
    .i_ctl_row    (ctl_row),
    .i_state      (u_ctrl.state),
    .i_next_busy  (i_next_busy),
    .i_next_start (o_next_start)
);

`default_nettype wire

// File: cim_tb.sv
`default_nettype none
`include "cim_params.svh"

module cim_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [11:0] CTRL_ADDR   = 12'h000;
    localparam logic [11:0] STATUS_ADDR = 12'h004;
    localparam logic [11:0] IN_BASE     = 12'h040;
    localparam logic [11:0] W_BASE      = 12'h400;
    localparam logic [11:0] ACC_BASE    = 12'h800;
    localparam int APB_CYCLES = 3;  // Setup, access, idle
    localparam int RUN_LIMIT  = 6 * APB_CYCLES * (`INPUT_SIZE + 64 + 40);

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        next_busy;
    logic        next_start;

    logic [`DATA_W-1:0] w_ref [`XBAR_SIZE][`OUT_COLS];
    logic [`DATA_W-1:0] in_ref [`INPUT_SIZE];
    logic [31:0]        rdata;
    int                 pulse_cnt;
    int                 pulses_before;
    int                 cycle_cnt;

    cim_layer_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .i_psel       (psel),
        .i_penable    (penable),
        .i_pwrite     (pwrite),
        .i_paddr      (paddr),
        .i_pwdata     (pwdata),
        .o_prdata     (prdata),
        .o_pready     (pready),
        .i_next_busy  (next_busy),
        .o_next_start (next_start)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Next-layer model counts handoff pulses
    always @(posedge clk) begin
        if (next_start) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < RUN_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles", RUN_LIMIT);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    end

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_acc(string name, logic [`ACC_W-1:0] exp, logic [`ACC_W-1:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_status(string name, logic [1:0] exp, logic [1:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            stop_with_error($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic apb_write(logic [11:0] addr, logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;  // Completes at the next rising edge
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(logic [11:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        if (!pready) begin
            stop_with_error("PREADY was low in an APB access phase");
        end
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic [11:0] weight_addr(int row, int col);
        return W_BASE + 12'(4 * (row * `OUT_COLS + col));
    endfunction

    // Column sum over the loaded rows
    function automatic logic [`ACC_W-1:0] ref_sum(int col);
        logic [`ACC_W-1:0] sum;
        sum = '0;
        for (int r = 0; r < `INPUT_SIZE; r++) begin
            sum += `ACC_W'(in_ref[r]) * `ACC_W'(w_ref[r][col]);
        end
        return sum;
    endfunction

    task automatic load_random_data();
        for (int r = 0; r < `XBAR_SIZE; r++) begin
            for (int c = 0; c < `OUT_COLS; c++) begin
                w_ref[r][c] = `DATA_W'($urandom);
                apb_write(weight_addr(r, c), 32'(w_ref[r][c]));
            end
        end
        for (int i = 0; i < `INPUT_SIZE; i++) begin
            in_ref[i] = `DATA_W'($urandom);
            apb_write(IN_BASE + 12'(4 * i), 32'(in_ref[i]));
        end
    endtask

    task automatic wait_done(string name);
        logic [31:0] st;
        st = '0;
        while (!st[1]) begin
            apb_read(STATUS_ADDR, st);
        end
        check_status({name, " status"}, 2'b10, st[1:0]);
    endtask

    task automatic check_sums(string name);
        logic [31:0] rd;
        for (int c = 0; c < `OUT_COLS; c++) begin
            apb_read(ACC_BASE + 12'(4 * c), rd);
            check_acc($sformatf("%s col %0d", name, c), ref_sum(c), rd[`ACC_W-1:0]);
        end
    endtask

    initial begin
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        next_busy = 1'b0;
        pulse_cnt = 0;
        void'($urandom(32'h4159));
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        apb_read(STATUS_ADDR, rdata);
        check_status("reset status", 2'b00, rdata[1:0]);
        repeat (10) @(negedge clk);
        check_count("reset pulses", 0, pulse_cnt);

        load_random_data();
        pulses_before = pulse_cnt;
        apb_write(CTRL_ADDR, 32'h1);
        wait_done("basic");
        check_count("basic pulses", pulses_before + 1, pulse_cnt);
        check_sums("basic");

        load_random_data();
        next_busy     = 1'b1;
        pulses_before = pulse_cnt;
        apb_write(CTRL_ADDR, 32'h1);
        repeat (1 + `INPUT_SIZE + 20) @(negedge clk);  // Load done, 20 cycles held
        apb_read(STATUS_ADDR, rdata);
        check_status("backpressure held", 2'b01, rdata[1:0]);
        check_count("backpressure held pulses", pulses_before, pulse_cnt);
        next_busy = 1'b0;
        wait_done("backpressure");
        check_count("backpressure pulses", pulses_before + 1, pulse_cnt);
        check_sums("backpressure");

        load_random_data();
        pulses_before = pulse_cnt;
        apb_write(CTRL_ADDR, 32'h1);
        for (int k = 0; k < 8; k++) begin
            apb_write(weight_addr(k, k % `OUT_COLS), 32'(w_ref[k][k % `OUT_COLS]));
        end
        wait_done("contention");
        check_count("contention pulses", pulses_before + 1, pulse_cnt);
        check_sums("contention");

        for (int run = 0; run < 3; run++) begin
            load_random_data();
            pulses_before = pulse_cnt;
            apb_write(CTRL_ADDR, 32'h1);
            apb_write(CTRL_ADDR, 32'h1);  // Lands while busy
            wait_done($sformatf("repeat %0d", run));
            repeat (10) @(negedge clk);
            apb_read(STATUS_ADDR, rdata);
            check_status($sformatf("repeat %0d idle", run), 2'b10, rdata[1:0]);
            check_count($sformatf("repeat %0d pulses", run), pulses_before + 1, pulse_cnt);
            check_sums($sformatf("repeat %0d", run));
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
cim_pkg.sv
cim_apb_regs.sv
cim_port_arbiter.sv
cim_layer_ctrl.sv
cim_xbar.sv
cim_layer_top.sv
cim_assert.sv
cim_tb.sv

// File: Makefile
TOP := cim_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
